/* build.f */
+incdir+.
csum_offload_pkg.sv
sync_fifo.sv
ones_sum32.sv
tx_frame_parser.sv
tx_csum_inserter.sv
eth_tx_csum_offload.sv
tb_eth_tx_csum_offload.sv

/* csum_offload_pkg.sv */
package csum_offload_pkg;

	////////////////////
	// Datapath sizing

	// Frame lengths and byte positions, frames up to 2047 bytes
	localparam int LEN_W = 11;

	// Metadata word is {length, checksum, insertion offset}
	localparam int META_W = 2 * LEN_W + 16;

	// Frame byte storage, holds at least two maximum frames
	localparam int DATA_FIFO_DEPTH = 4096;

	// Queued frame descriptors
	localparam int META_FIFO_DEPTH = 32;

	////////////////////
	// Protocol constants

	// Ethertype for IPv4
	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

	// IPv4 protocol numbers we offload
	localparam logic [7:0] IP_PROTO_TCP = 8'd6;
	localparam logic [7:0] IP_PROTO_UDP = 8'd17;

	// Header sizes, IPv4 without options
	localparam int MAC_HDR_LEN = 14;
	localparam int IPV4_HDR_LEN = 20;

	// Checksum field position inside the layer-4 header
	localparam int TCP_CSUM_OFS = 16;
	localparam int UDP_CSUM_OFS = 6;

endpackage

/* eth_tx_csum_offload.sv */
`timescale 1ns/1ns

module eth_tx_csum_offload (
	input logic clk,
	input logic rst_n,
	input logic buf_start,
	input logic buf_valid,
	input logic [7:0] buf_data,
	output logic buf_ready,
	input logic mac_ready,
	output logic mac_start,
	output logic mac_valid,
	output logic [7:0] mac_data
);

	// Accumulator controls
	logic csum_clear;
	logic csum_add;
	logic [31:0] csum_word;
	logic [15:0] csum_sum;

	// Metadata write side
	logic meta_wr;
	logic [csum_offload_pkg::LEN_W-1:0] meta_len;
	logic [15:0] meta_csum;
	logic [csum_offload_pkg::LEN_W-1:0] meta_ofs;

	// Metadata read side
	logic meta_rd;
	logic meta_empty;
	logic [csum_offload_pkg::LEN_W-1:0] rd_len;
	logic [15:0] rd_csum;
	logic [csum_offload_pkg::LEN_W-1:0] rd_ofs;

	// Frame byte readback
	logic fifo_rd;
	logic [7:0] fifo_data;

	////////////////////
	// Ingress side

	tx_frame_parser u_parser (.clk(clk), .rst_n(rst_n), .buf_start(buf_start),
		.buf_valid(buf_valid), .buf_data(buf_data), .csum_sum(csum_sum), .buf_ready(buf_ready),
		.csum_clear(csum_clear), .csum_add(csum_add), .csum_word(csum_word), .meta_wr(meta_wr),
		.meta_len(meta_len), .meta_csum(meta_csum), .meta_ofs(meta_ofs));

	ones_sum32 u_sum (.clk(clk), .rst_n(rst_n), .clear(csum_clear), .add(csum_add),
		.din(csum_word), .sum(csum_sum));

	// Every input byte is stored, parsing runs alongside
	sync_fifo #(.WIDTH(8), .DEPTH(csum_offload_pkg::DATA_FIFO_DEPTH)) data_fifo (.clk(clk),
		.rst_n(rst_n), .wr(buf_valid), .din(buf_data), .rd(fifo_rd), .dout(fifo_data), .empty());

	// One descriptor per frame, {length, checksum, offset}
	sync_fifo #(.WIDTH(csum_offload_pkg::META_W), .DEPTH(csum_offload_pkg::META_FIFO_DEPTH))
		meta_fifo (.clk(clk), .rst_n(rst_n), .wr(meta_wr), .din({meta_len, meta_csum, meta_ofs}),
		.rd(meta_rd), .dout({rd_len, rd_csum, rd_ofs}), .empty(meta_empty));

	////////////////////
	// Egress side

	tx_csum_inserter u_inserter (.clk(clk), .rst_n(rst_n), .mac_ready(mac_ready),
		.meta_empty(meta_empty), .meta_len(rd_len), .meta_csum(rd_csum), .meta_ofs(rd_ofs),
		.fifo_data(fifo_data), .meta_rd(meta_rd), .fifo_rd(fifo_rd), .mac_start(mac_start),
		.mac_valid(mac_valid), .mac_data(mac_data));

endmodule

/* ones_sum32.sv */
`timescale 1ns/1ns

module ones_sum32 (
	input logic clk,
	input logic rst_n,
	input logic clear,
	input logic add,
	input logic [31:0] din,
	output logic [15:0] sum
);

	// Three 16-bit terms need two carry bits
	logic [17:0] raw;

	// First fold may carry once more
	logic [16:0] fold1;

	// Second fold cannot overflow
	logic [15:0] fold2;

	////////////////////
	// End-around carry

	always_comb begin
		// Running sum plus both halves of the word
		raw = {2'b00, sum} + {2'b00, din[31:16]} + {2'b00, din[15:0]};
		// Wrap the carries back into bit 0
		fold1 = {1'b0, raw[15:0]} + {15'h0000, raw[17:16]};
		// If fold1 carried its low half is at most 1
		fold2 = fold1[15:0] + {15'h0000, fold1[16]};
	end

	////////////////////
	// Accumulator register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sum <= '0;
		// Clear wins over add
		else if (clear)
			sum <= '0;
		else if (add)
			sum <= fold2;
	end

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [WIDTH-1:0] din,
	input logic rd,
	output logic [WIDTH-1:0] dout,
	output logic empty
);

	// Storage array
	logic [WIDTH-1:0] mem [DEPTH];

	// Pointers carry one bit above the address
	logic [$clog2(DEPTH):0] wr_ptr;
	logic [$clog2(DEPTH):0] rd_ptr;

	// Pointer values after this cycle
	logic [$clog2(DEPTH):0] wr_ptr_nxt;
	logic [$clog2(DEPTH):0] rd_ptr_nxt;

	// Pop only when something is stored
	logic do_rd;

	assign do_rd = rd && !empty;

	always_comb begin
		wr_ptr_nxt = wr ? wr_ptr + 1'b1 : wr_ptr;
		rd_ptr_nxt = do_rd ? rd_ptr + 1'b1 : rd_ptr;
	end

	////////////////////
	// Pointers and flag

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			empty <= 1'b1;
		end else begin
			wr_ptr <= wr_ptr_nxt;
			rd_ptr <= rd_ptr_nxt;
			// Flag matches the pointers it is registered with
			empty <= (wr_ptr_nxt == rd_ptr_nxt);
		end
	end

	////////////////////
	// Memory and read port

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr[$clog2(DEPTH)-1:0]] <= din;
		// Read data shows up the cycle after rd
		if (do_rd)
			dout <= mem[rd_ptr[$clog2(DEPTH)-1:0]];
	end

endmodule

/* tb_frame_model.svh */
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Frame kinds the builder knows
localparam int KIND_TCP = 0;
localparam int KIND_UDP = 1;
localparam int KIND_ICMP = 2;
localparam int KIND_RAW = 3;

// Where the IPv4 and layer-4 headers begin
localparam int IP_START = csum_offload_pkg::MAC_HDR_LEN;
localparam int L4_START = csum_offload_pkg::MAC_HDR_LEN + csum_offload_pkg::IPV4_HDR_LEN;

// Frame under construction, one byte per entry
logic [7:0] tx_frame [0:2047];
int tx_len;

// Payload generator state
integer seed = 77;

// ICMP echo header is 8 bytes like UDP
function automatic int l4_hdr_len(input int kind);
	return (kind == KIND_TCP) ? 20 : 8;
endfunction

function automatic int frame_size(input int kind, input int plen);
	if (kind == KIND_RAW)
		return IP_START + plen;
	return L4_START + l4_hdr_len(kind) + plen;
endfunction

// Frame position of the checksum high byte, 0 when nothing is offloaded
function automatic int csum_frame_ofs(input int kind);
	if (kind == KIND_TCP)
		return L4_START + csum_offload_pkg::TCP_CSUM_OFS;
	if (kind == KIND_UDP)
		return L4_START + csum_offload_pkg::UDP_CSUM_OFS;
	return 0;
endfunction

task automatic build_frame(input int kind, input int plen);
	logic [31:0] r;
	logic [15:0] etype;
	logic [15:0] fld;
	int i;
	tx_len = frame_size(kind, plen);
	// Random everywhere first, so the stored checksum is garbage
	for (i = 0; i < tx_len; i++) begin
		r = $random(seed);
		tx_frame[i] = r[7:0];
	end
	// Locally administered unicast addresses
	tx_frame[0] = 8'h02;
	tx_frame[6] = 8'h02;
	// ARP ethertype stands in for any non-IP frame
	etype = (kind == KIND_RAW) ? 16'h0806 : csum_offload_pkg::ETHERTYPE_IPV4;
	tx_frame[12] = etype[15:8];
	tx_frame[13] = etype[7:0];
	if (kind != KIND_RAW) begin
		// Version 4, IHL 5
		tx_frame[IP_START] = 8'h45;
		fld = 16'(tx_len - IP_START);
		tx_frame[IP_START + 2] = fld[15:8];
		tx_frame[IP_START + 3] = fld[7:0];
		tx_frame[IP_START + 9] = (kind == KIND_TCP) ? csum_offload_pkg::IP_PROTO_TCP
			: (kind == KIND_UDP) ? csum_offload_pkg::IP_PROTO_UDP : 8'd1;
		if (kind == KIND_UDP) begin
			// UDP length covers header and payload
			fld = 16'(tx_len - L4_START);
			tx_frame[L4_START + 4] = fld[15:8];
			tx_frame[L4_START + 5] = fld[7:0];
		end
	end
endtask

// Pseudo-header and layer-4 bytes, stored field as zero, odd tail padded
function automatic logic [15:0] ref_l4_csum(input int csum_pos);
	logic [31:0] acc;
	logic [7:0] hi;
	logic [7:0] lo;
	int l4_len;
	int i;
	l4_len = tx_len - L4_START;
	// Length term and 00:protocol
	acc = 32'(l4_len) + {24'h000000, tx_frame[IP_START + 9]};
	// Source then destination address
	for (i = IP_START + 12; i < L4_START; i += 2)
		acc += {16'h0000, tx_frame[i], tx_frame[i + 1]};
	for (i = 0; i < l4_len; i += 2) begin
		hi = (i == csum_pos) ? 8'h00 : tx_frame[L4_START + i];
		lo = (i + 1 >= l4_len || i == csum_pos) ? 8'h00 : tx_frame[L4_START + i + 1];
		acc += {16'h0000, hi, lo};
	end
	// Fold carries back in until none are left
	while (acc[31:16] != 16'h0000)
		acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
	return ~acc[15:0];
endfunction

`endif

/* tb_eth_tx_csum_offload.sv */
`timescale 1ns/1ns

module tb_eth_tx_csum_offload;

	logic clk;
	logic rst_n;
	logic buf_start;
	logic buf_valid;
	logic [7:0] buf_data;
	logic buf_ready;
	logic mac_ready;
	logic mac_start;
	logic mac_valid;
	logic [7:0] mac_data;

	`include "tb_frame_model.svh"

	// Every frame of the run, tests pick them by index
	localparam int NUM_FRAMES = 11;
	int spec_kind [NUM_FRAMES] = '{KIND_TCP, KIND_UDP, KIND_ICMP, KIND_RAW, KIND_TCP,
		KIND_UDP, KIND_RAW, KIND_TCP, KIND_UDP, KIND_ICMP, KIND_TCP};
	int spec_plen [NUM_FRAMES] = '{40, 33, 20, 46, 15, 10, 50, 100, 51, 30, 7};

	// Expected frames in send order
	logic [7:0] exp_bytes [$];
	int exp_lens [$];
	int exp_ofs [$];
	logic [15:0] exp_csums [$];
	// Frames seen at the MAC
	logic [7:0] rx_bytes [$];
	int rx_lens [$];
	int starts_seen = 0;
	logic overlap_seen = 1'b0;

	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int cycle_limit;

	eth_tx_csum_offload DUT (.clk(clk), .rst_n(rst_n), .buf_start(buf_start),
		.buf_valid(buf_valid), .buf_data(buf_data), .buf_ready(buf_ready),
		.mac_ready(mac_ready), .mac_start(mac_start), .mac_valid(mac_valid),
		.mac_data(mac_data));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Watchdog

	// Three cycles per byte plus slack per frame
	function automatic int run_cycle_limit();
		int total;
		int i;
		total = 0;
		for (i = 0; i < NUM_FRAMES; i++)
			total += frame_size(spec_kind[i], spec_plen[i]);
		return 3 * total + 200 * NUM_FRAMES;
	endfunction

	initial begin
		cycle_limit = run_cycle_limit();
		while (cycle_count <= cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("ERROR: run still busy after %0d cycles, frames never finished", cycle_limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////
	// MAC side monitor

	task automatic capture_frame();
		int n;
		n = 0;
		while (mac_start !== 1'b1)
			@(negedge clk);
		starts_seen++;
		// First byte follows two cycles after mac_start
		do
			@(negedge clk);
		while (mac_valid !== 1'b1);
		while (mac_valid === 1'b1) begin
			rx_bytes.push_back(mac_data);
			n++;
			@(negedge clk);
		end
		rx_lens.push_back(n);
	endtask

	initial begin
		@(posedge rst_n);
		forever
			capture_frame();
	end

	// Ingress and egress busy in the same cycle
	always @(negedge clk)
		if (buf_valid === 1'b1 && mac_valid === 1'b1)
			overlap_seen = 1'b1;

	////////////////////
	// Compare tasks

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_csum(input logic [15:0] got, input logic [15:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t ns: %s got %04h expected %04h", $time, what, got, exp);
		end
	endtask

	task automatic check_len(input logic [csum_offload_pkg::LEN_W-1:0] got,
		input logic [csum_offload_pkg::LEN_W-1:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////
	// Drive and verify

	// Inputs change 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic send_frame(input int idx);
		int i;
		int ofs;
		build_frame(spec_kind[idx], spec_plen[idx]);
		ofs = csum_frame_ofs(spec_kind[idx]);
		exp_lens.push_back(tx_len);
		exp_ofs.push_back(ofs);
		exp_csums.push_back((ofs != 0) ? ref_l4_csum(ofs - L4_START) : 16'h0000);
		for (i = 0; i < tx_len; i++)
			exp_bytes.push_back(tx_frame[i]);
		step();
		while (buf_ready !== 1'b1)
			step();
		buf_start = 1'b1;
		step();
		buf_start = 1'b0;
		for (i = 0; i < tx_len; i++) begin
			buf_valid = 1'b1;
			buf_data = tx_frame[i];
			step();
		end
		// Frame ends on the first idle cycle
		buf_valid = 1'b0;
		buf_data = 8'h00;
	endtask

	task automatic verify_frame(input int idx);
		int len_exp;
		int len_got;
		int ofs;
		int i;
		logic [15:0] csum_exp;
		logic [15:0] csum_got;
		logic [7:0] b_exp;
		logic [7:0] b_got;
		len_exp = exp_lens.pop_front();
		ofs = exp_ofs.pop_front();
		csum_exp = exp_csums.pop_front();
		len_got = rx_lens.pop_front();
		csum_got = 16'h0000;
		check_len(csum_offload_pkg::LEN_W'(len_got), csum_offload_pkg::LEN_W'(len_exp),
			$sformatf("frame %0d length", idx));
		for (i = 0; i < len_exp; i++) begin
			b_exp = exp_bytes.pop_front();
			if (i < len_got) begin
				b_got = rx_bytes[i];
				// Checksum bytes are compared as one field
				if (ofs != 0 && i == ofs)
					csum_got[15:8] = b_got;
				else if (ofs != 0 && i == ofs + 1)
					csum_got[7:0] = b_got;
				else
					check_byte(b_got, b_exp, $sformatf("frame %0d byte %0d", idx, i));
			end
		end
		if (ofs != 0)
			check_csum(csum_got, csum_exp, $sformatf("frame %0d checksum", idx));
		for (i = 0; i < len_got; i++)
			b_got = rx_bytes.pop_front();
	endtask

	// Send a run of frames, wait for all at the MAC, check in order
	task automatic run_batch(input int first, input int count);
		int i;
		for (i = first; i < first + count; i++)
			send_frame(i);
		while (rx_lens.size() < count)
			@(negedge clk);
		for (i = first; i < first + count; i++)
			verify_frame(i);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errs_before);
		end
	endtask

	////////////////////
	// Directed tests

	task automatic test_reset_idle();
		int errs;
		int i;
		logic quiet;
		errs = error_count;
		quiet = 1'b1;
		step();
		if (buf_ready !== 1'b1) begin
			error_count++;
			$display("ERROR at %0t ns: buf_ready not high one cycle after reset", $time);
		end
		for (i = 0; i < 50; i++) begin
			@(negedge clk);
			quiet &= (mac_start === 1'b0) && (mac_valid === 1'b0);
		end
		if (!quiet) begin
			error_count++;
			$display("ERROR: MAC output became active with nothing queued");
		end
		finish_test("reset_idle", errs);
	endtask

	task automatic test_tcp_even();
		int errs;
		errs = error_count;
		run_batch(0, 1);
		finish_test("tcp_even", errs);
	endtask

	task automatic test_udp_odd();
		int errs;
		errs = error_count;
		run_batch(1, 1);
		finish_test("udp_odd", errs);
	endtask

	// ICMP and non-IP go through untouched
	task automatic test_passthrough();
		int errs;
		errs = error_count;
		run_batch(2, 2);
		finish_test("passthrough", errs);
	endtask

	task automatic test_mac_hold();
		int errs;
		int starts;
		int i;
		errs = error_count;
		step();
		mac_ready = 1'b0;
		starts = starts_seen;
		for (i = 4; i < 7; i++)
			send_frame(i);
		// Room for the last descriptor to reach the inserter
		repeat (20)
			step();
		if (starts_seen != starts) begin
			error_count++;
			$display("ERROR at %0t ns: frame started while mac_ready was low", $time);
		end
		mac_ready = 1'b1;
		while (rx_lens.size() < 3)
			@(negedge clk);
		for (i = 4; i < 7; i++)
			verify_frame(i);
		finish_test("mac_hold", errs);
	endtask

	task automatic test_back_to_back();
		int errs;
		errs = error_count;
		overlap_seen = 1'b0;
		run_batch(7, 4);
		if (!overlap_seen) begin
			error_count++;
			$display("ERROR: no frame was parsed while another was replayed");
		end
		finish_test("back_to_back", errs);
	endtask

	initial begin
		rst_n = 1'b0;
		buf_start = 1'b0;
		buf_valid = 1'b0;
		buf_data = 8'h00;
		mac_ready = 1'b1;
		repeat (16)
			@(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset_idle();
		test_tcp_even();
		test_udp_odd();
		test_passthrough();
		test_mac_hold();
		test_back_to_back();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* tx_csum_inserter.sv */
`timescale 1ns/1ns

module tx_csum_inserter (
	input logic clk,
	input logic rst_n,
	input logic mac_ready,
	input logic meta_empty,
	input logic [csum_offload_pkg::LEN_W-1:0] meta_len,
	input logic [15:0] meta_csum,
	input logic [csum_offload_pkg::LEN_W-1:0] meta_ofs,
	input logic [7:0] fifo_data,
	output logic meta_rd,
	output logic fifo_rd,
	output logic mac_start,
	output logic mac_valid,
	output logic [7:0] mac_data
);

	// Readback states
	enum logic [1:0] {
		RD_IDLE,
		RD_POP,
		RD_FORWARD,
		RD_LAST
	} state;

	// Frame index of the byte now on fifo_data
	logic [csum_offload_pkg::LEN_W-1:0] rd_count;

	// Byte to send after checksum substitution
	logic [7:0] out_byte;

	////////////////////
	// Checksum substitution

	always_comb begin
		out_byte = fifo_data;
		// Offset zero means pass through
		if (meta_ofs != '0) begin
			if (rd_count == meta_ofs)
				out_byte = meta_csum[15:8];
			else if (rd_count == meta_ofs + 1'b1)
				out_byte = meta_csum[7:0];
		end
	end

	////////////////////
	// Readback FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RD_IDLE;
			rd_count <= '0;
			meta_rd <= 1'b0;
			fifo_rd <= 1'b0;
			mac_start <= 1'b0;
			mac_valid <= 1'b0;
			mac_data <= '0;
		end else begin
			meta_rd <= 1'b0;
			fifo_rd <= 1'b0;
			mac_start <= 1'b0;
			mac_valid <= 1'b0;
			case (state)
				RD_IDLE: begin
					// MAC readiness only matters between frames
					if (mac_ready && !meta_empty) begin
						meta_rd <= 1'b1;
						fifo_rd <= 1'b1;
						mac_start <= 1'b1;
						state <= RD_POP;
					end
				end
				RD_POP: begin
					// Second byte read keeps the pipe two deep
					fifo_rd <= 1'b1;
					rd_count <= '0;
					state <= RD_FORWARD;
				end
				RD_FORWARD: begin
					mac_valid <= 1'b1;
					mac_data <= out_byte;
					rd_count <= rd_count + 1'b1;
					// Stop fetching once the last byte is requested
					if (rd_count + 2 >= meta_len)
						state <= RD_LAST;
					else
						fifo_rd <= 1'b1;
				end
				RD_LAST: begin
					// final byte, may itself be a checksum byte
					mac_valid <= 1'b1;
					mac_data <= out_byte;
					state <= RD_IDLE;
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

/* tx_frame_parser.sv */
`timescale 1ns/1ns

module tx_frame_parser (
	input logic clk,
	input logic rst_n,
	input logic buf_start,
	input logic buf_valid,
	input logic [7:0] buf_data,
	input logic [15:0] csum_sum,
	output logic buf_ready,
	output logic csum_clear,
	output logic csum_add,
	output logic [31:0] csum_word,
	output logic meta_wr,
	output logic [csum_offload_pkg::LEN_W-1:0] meta_len,
	output logic [15:0] meta_csum,
	output logic [csum_offload_pkg::LEN_W-1:0] meta_ofs
);

	// Parse states, rest state ignores stray bytes
	enum logic [3:0] {
		ST_IGNORE,
		ST_MAC_HDR,
		ST_IPV4_HDR,
		ST_TCP_DATA,
		ST_UDP_DATA,
		ST_LEN,
		ST_SAVE,
		ST_UNKNOWN
	} state;

	// Byte index within the current header or layer-4 section
	logic [csum_offload_pkg::LEN_W-1:0] count;
	// Bytes seen so far in the whole frame
	logic [csum_offload_pkg::LEN_W-1:0] frame_len;
	// Captured header fields
	logic [7:0] ethertype_hi;
	logic [7:0] ip_proto;
	// Checksum field position for the current protocol
	logic [csum_offload_pkg::LEN_W-1:0] csum_ofs;
	logic is_csum_byte;
	// Top bit of the word lane this byte lands in, lane 0 is the MSB
	logic [4:0] lane_hi;

	always_comb begin
		csum_ofs = (state == ST_TCP_DATA) ? csum_offload_pkg::LEN_W'(csum_offload_pkg::TCP_CSUM_OFS)
			: csum_offload_pkg::LEN_W'(csum_offload_pkg::UDP_CSUM_OFS);
		is_csum_byte = (count == csum_ofs) || (count == csum_ofs + 1'b1);
		lane_hi = 5'd31 - {count[1:0], 3'b000};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IGNORE;
			buf_ready <= 1'b0;
			csum_clear <= 1'b0;
			csum_add <= 1'b0;
			csum_word <= '0;
			meta_wr <= 1'b0;
			meta_len <= '0;
			meta_csum <= '0;
			meta_ofs <= '0;
			count <= '0;
			frame_len <= '0;
			ethertype_hi <= '0;
			ip_proto <= '0;
		end else begin
			// Single-cycle strobes
			csum_clear <= 1'b0;
			csum_add <= 1'b0;
			meta_wr <= 1'b0;
			// Busy while a checksum frame is in progress
			buf_ready <= (state == ST_IGNORE) || (state == ST_UNKNOWN);

			////////////////////
			// Byte processing
			if (buf_valid) begin
				frame_len <= frame_len + 1'b1;
				count <= count + 1'b1;
				case (state)
					ST_MAC_HDR: begin
						// Ethertype is the last two header bytes
						if (count == csum_offload_pkg::MAC_HDR_LEN - 2)
							ethertype_hi <= buf_data;
						if (count == csum_offload_pkg::MAC_HDR_LEN - 1) begin
							count <= '0;
							if ({ethertype_hi, buf_data} == csum_offload_pkg::ETHERTYPE_IPV4)
								state <= ST_IPV4_HDR;
							else
								state <= ST_UNKNOWN;
						end
					end
					ST_IPV4_HDR: begin
						// Protocol goes into the pseudo-header as 00:proto
						if (count == 9) begin
							ip_proto <= buf_data;
							csum_word <= {24'h000000, buf_data};
							csum_add <= 1'b1;
						end
						// Source then destination address, one word each
						if (count >= 12) begin
							csum_word[lane_hi -: 8] <= buf_data;
							if (count[1:0] == 2'd3)
								csum_add <= 1'b1;
						end
						if (count == csum_offload_pkg::IPV4_HDR_LEN - 1) begin
							count <= '0;
							if (ip_proto == csum_offload_pkg::IP_PROTO_TCP)
								state <= ST_TCP_DATA;
							else if (ip_proto == csum_offload_pkg::IP_PROTO_UDP)
								state <= ST_UDP_DATA;
							else
								state <= ST_UNKNOWN;
						end
					end
					ST_TCP_DATA, ST_UDP_DATA: begin
						// Stored checksum counts as zero
						csum_word[lane_hi -: 8] <= is_csum_byte ? 8'h00 : buf_data;
						// Remember where the high checksum byte sits in the frame
						if (count == csum_ofs)
							meta_ofs <= frame_len;
						if (count[1:0] == 2'd3)
							csum_add <= 1'b1;
					end
					default: begin
					end
				endcase
			end

			////////////////////
			// Frame end handling
			else begin
				case (state)
					ST_TCP_DATA, ST_UDP_DATA: begin
						// Zero-pad the partial trailing word
						for (int i = 0; i < 4; i++) begin
							if (i >= count[1:0])
								csum_word[31 - 8*i -: 8] <= 8'h00;
						end
						csum_add <= 1'b1;
						state <= ST_LEN;
					end
					ST_LEN: begin
						// Layer-4 length term of the pseudo-header
						csum_word <= {{(32 - csum_offload_pkg::LEN_W){1'b0}}, count};
						csum_add <= 1'b1;
						state <= ST_SAVE;
					end
					ST_SAVE: begin
						// Wait out the last add before taking the sum
						if (!csum_add) begin
							meta_wr <= 1'b1;
							meta_len <= frame_len;
							meta_csum <= ~csum_sum;
							buf_ready <= 1'b1;
							state <= ST_IGNORE;
						end
					end
					ST_MAC_HDR, ST_IPV4_HDR, ST_UNKNOWN: begin
						// Pass through, offset zero means leave untouched
						meta_wr <= 1'b1;
						meta_len <= frame_len;
						meta_csum <= '0;
						meta_ofs <= '0;
						state <= ST_IGNORE;
					end
					default: begin
					end
				endcase
			end

			// New frame restarts everything
			if (buf_start) begin
				state <= ST_MAC_HDR;
				count <= '0;
				frame_len <= '0;
				meta_ofs <= '0;
				csum_clear <= 1'b1;
				buf_ready <= 1'b0;
			end
		end
	end

endmodule
